// File: design/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NUM_REGS 32

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 64

`endif

// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SRA = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SLT = 4'd8,
        ALU_EQ  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I  = 2'd0,
        IMM_S  = 2'd1,
        IMM_SB = 2'd2,
        IMM_UJ = 2'd3
    } imm_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src;     // Operand B from immediate
        logic    jal;
        logic    jalr;
        logic    branch;
        logic    bne;         // Inverts the equality result
        logic    mem_to_reg;
        logic    mem_wen;
        logic    mem_ren;
        logic    reg_wen;
    } ctrl_t;

endpackage

`default_nettype wire

// File: design/decode_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_cfg.svh"

interface decode_if;

    rv_pkg::ctrl_t        ctrl;
    logic [`RV_XLEN-1:0]  imm;   // Sign-extended
    logic [4:0]           rd;

    modport producer (
        output ctrl,
        output imm,
        output rd
    );

    modport consumer (
        input ctrl,
        input imm,
        input rd
    );

endinterface

`default_nettype wire

// File: design/decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_cfg.svh"

module decoder (
    input  wire logic [31:0] inst_i,
    decode_if.producer       dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic [`RV_XLEN-1:0] i_imm;
    logic [`RV_XLEN-1:0] s_imm;
    logic [`RV_XLEN-1:0] sb_imm;
    logic [`RV_XLEN-1:0] uj_imm;
    logic [`RV_XLEN-1:0] imm_ext;

    rv_pkg::imm_sel_e imm_sel;
    rv_pkg::ctrl_t    ctrl;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign i_imm  = {{(`RV_XLEN - 12){inst_i[31]}}, inst_i[31:20]};
    assign s_imm  = {{(`RV_XLEN - 12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign sb_imm = {{(`RV_XLEN - 13){inst_i[31]}}, inst_i[31], inst_i[7],
                     inst_i[30:25], inst_i[11:8], 1'b0};
    assign uj_imm = {{(`RV_XLEN - 21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                     inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        ctrl    = '0;   // All enables low, ALU add
        imm_sel = rv_pkg::IMM_I;
        case (opcode)
            rv_pkg::OPCODE_OP: begin
                ctrl.reg_wen = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001:  ctrl.alu_op = rv_pkg::ALU_SLL;
                    3'b010:  ctrl.alu_op = rv_pkg::ALU_SLT;
                    3'b100:  ctrl.alu_op = rv_pkg::ALU_XOR;
                    3'b101:  ctrl.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110:  ctrl.alu_op = rv_pkg::ALU_OR;
                    3'b111:  ctrl.alu_op = rv_pkg::ALU_AND;
                    default: ctrl.alu_op = rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OPCODE_OPIMM: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = 1'b1;
                // No SUBI, bit 30 only matters for shifts
                case (funct3)
                    3'b001:  ctrl.alu_op = rv_pkg::ALU_SLL;
                    3'b010:  ctrl.alu_op = rv_pkg::ALU_SLT;
                    3'b100:  ctrl.alu_op = rv_pkg::ALU_XOR;
                    3'b101:  ctrl.alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110:  ctrl.alu_op = rv_pkg::ALU_OR;
                    3'b111:  ctrl.alu_op = rv_pkg::ALU_AND;
                    default: ctrl.alu_op = rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OPCODE_LOAD: begin
                ctrl.alu_src    = 1'b1;   // rs1 + imm address
                ctrl.mem_ren    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_wen    = 1'b1;
            end
            rv_pkg::OPCODE_STORE: begin
                ctrl.alu_src = 1'b1;
                ctrl.mem_wen = 1'b1;
                imm_sel      = rv_pkg::IMM_S;
            end
            rv_pkg::OPCODE_BRANCH: begin
                ctrl.alu_op = rv_pkg::ALU_EQ;   // Compare rs1 with rs2
                ctrl.branch = 1'b1;
                ctrl.bne    = funct3[0];
                imm_sel     = rv_pkg::IMM_SB;
            end
            rv_pkg::OPCODE_JAL: begin
                ctrl.jal     = 1'b1;
                ctrl.reg_wen = 1'b1;
                imm_sel      = rv_pkg::IMM_UJ;
            end
            rv_pkg::OPCODE_JALR: begin
                ctrl.jalr    = 1'b1;
                ctrl.alu_src = 1'b1;   // Target from ALU
                ctrl.reg_wen = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_comb begin
        case (imm_sel)
            rv_pkg::IMM_S:  imm_ext = s_imm;
            rv_pkg::IMM_SB: imm_ext = sb_imm;
            rv_pkg::IMM_UJ: imm_ext = uj_imm;
            default:        imm_ext = i_imm;
        endcase
    end

    assign dec_o.ctrl = ctrl;
    assign dec_o.imm  = imm_ext;
    assign dec_o.rd   = inst_i[11:7];

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_cfg.svh"

module reg_file (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic [4:0]          rs1_addr_i,
    input  wire logic [4:0]          rs2_addr_i,
    output logic      [`RV_XLEN-1:0] rs1_data_o,
    output logic      [`RV_XLEN-1:0] rs2_data_o,
    input  wire logic                we_i,
    input  wire logic [4:0]          waddr_i,
    input  wire logic [`RV_XLEN-1:0] wdata_i
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero regardless of contents
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: design/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_cfg.svh"

module exec_unit (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic                valid_i,
    input  wire logic [`RV_XLEN-1:0] pc_i,
    decode_if.consumer               dec_i,
    input  wire logic [`RV_XLEN-1:0] rs1_data_i,
    input  wire logic [`RV_XLEN-1:0] rs2_data_i,
    output logic                     rf_we_o,
    output logic      [4:0]          rf_waddr_o,
    output logic      [`RV_XLEN-1:0] rf_wdata_o,
    output logic                     wb_valid_o,
    output logic                     wb_we_o,
    output logic      [4:0]          wb_rd_o,
    output logic      [`RV_XLEN-1:0] wb_data_o,
    output logic      [`RV_XLEN-1:0] next_pc_o,
    output logic                     branch_taken_o
);

    localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] link;
    logic [`RV_XLEN-1:0] pc_rel;
    logic [`RV_XLEN-1:0] next_pc;
    logic                taken;
    logic [DMEM_AW-1:0]  dmem_idx;
    logic [`RV_XLEN-1:0] dmem_rdata;

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];

    assign op_b  = dec_i.ctrl.alu_src ? dec_i.imm : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_i.ctrl.alu_op)
            rv_pkg::ALU_ADD: alu_res = rs1_data_i + op_b;
            rv_pkg::ALU_SUB: alu_res = rs1_data_i - op_b;
            rv_pkg::ALU_AND: alu_res = rs1_data_i & op_b;
            rv_pkg::ALU_OR:  alu_res = rs1_data_i | op_b;
            rv_pkg::ALU_XOR: alu_res = rs1_data_i ^ op_b;
            rv_pkg::ALU_SRA: alu_res = $signed(rs1_data_i) >>> shamt;
            rv_pkg::ALU_SRL: alu_res = rs1_data_i >> shamt;
            rv_pkg::ALU_SLL: alu_res = rs1_data_i << shamt;
            rv_pkg::ALU_SLT: alu_res = {{(`RV_XLEN - 1){1'b0}},
                                        $signed(rs1_data_i) < $signed(op_b)};
            rv_pkg::ALU_EQ:  alu_res = {{(`RV_XLEN - 1){1'b0}}, rs1_data_i == op_b};
            default:         alu_res = '0;
        endcase
    end

    // Equality flips for BNE
    assign taken  = dec_i.ctrl.branch & (alu_res[0] ^ dec_i.ctrl.bne);
    assign link   = pc_i + `RV_XLEN'd4;
    assign pc_rel = pc_i + dec_i.imm;   // Branch and JAL target

    always_comb begin
        if (dec_i.ctrl.jalr) begin
            next_pc = {alu_res[`RV_XLEN-1:1], 1'b0};
        end else if (dec_i.ctrl.jal || taken) begin
            next_pc = pc_rel;
        end else begin
            next_pc = link;
        end
    end

    assign dmem_idx   = alu_res[DMEM_AW+1:2];   // Word index
    assign dmem_rdata = dec_i.ctrl.mem_ren ? dmem[dmem_idx] : '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (valid_i && dec_i.ctrl.mem_wen) begin
            dmem[dmem_idx] <= rs2_data_i;
        end
    end

    assign rf_we_o    = valid_i & dec_i.ctrl.reg_wen & (dec_i.rd != 5'd0);
    assign rf_waddr_o = dec_i.rd;

    always_comb begin
        if (dec_i.ctrl.mem_to_reg) begin
            rf_wdata_o = dmem_rdata;
        end else if (dec_i.ctrl.jal || dec_i.ctrl.jalr) begin
            rf_wdata_o = link;
        end else begin
            rf_wdata_o = alu_res;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o     <= 1'b0;
            wb_we_o        <= 1'b0;
            branch_taken_o <= 1'b0;
            next_pc_o      <= '0;
        end else begin
            wb_valid_o <= valid_i;   // One cycle behind the strobe
            if (valid_i) begin
                wb_we_o        <= rf_we_o;
                branch_taken_o <= taken;
                next_pc_o      <= next_pc;
            end
        end
    end

    // Record payload holds between strobes
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wb_rd_o   <= dec_i.rd;
            wb_data_o <= rf_wdata_o;
        end
    end

endmodule

`default_nettype wire

// File: design/rv_exec_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_core_cfg.svh"

module rv_exec_top (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic                inst_valid_i,
    input  wire logic [31:0]         inst_i,
    input  wire logic [`RV_XLEN-1:0] pc_i,
    output logic                     wb_valid_o,
    output logic                     wb_we_o,
    output logic                     branch_taken_o,
    output logic      [4:0]          wb_rd_o,
    output logic      [`RV_XLEN-1:0] wb_data_o,
    output logic      [`RV_XLEN-1:0] next_pc_o
);

    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                rf_we;
    logic [4:0]          rf_waddr;
    logic [`RV_XLEN-1:0] rf_wdata;

    decode_if dec_bus ();

    decoder u_decoder (
        .inst_i (inst_i),
        .dec_o  (dec_bus)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (inst_i[19:15]),
        .rs2_addr_i (inst_i[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata)
    );

    exec_unit u_exec_unit (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .valid_i        (inst_valid_i),
        .pc_i           (pc_i),
        .dec_i          (dec_bus),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .wb_valid_o     (wb_valid_o),
        .wb_we_o        (wb_we_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .next_pc_o      (next_pc_o),
        .branch_taken_o (branch_taken_o)
    );

endmodule

`default_nettype wire

// File: dv/rv_exec_chk.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exec_chk (
    input wire logic        clk_i,
    input wire logic        rst_i,
    input wire logic        inst_valid_i,
    input wire logic [31:0] inst_i,
    input wire logic [31:0] rs1_data_i,
    input wire logic [31:0] rs2_data_i,
    input wire logic        wb_valid_i,
    input wire logic        wb_we_i,
    input wire logic [4:0]  wb_rd_i,
    input wire logic        branch_taken_i
);

    int unsigned fail_count = 0;

    wb_after_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
        inst_valid_i |=> wb_valid_i)
        else begin $error("wb_valid_o missing one cycle after a strobe"); fail_count++; end

    wb_only_after_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
        !inst_valid_i |=> !wb_valid_i)
        else begin $error("wb_valid_o raised without a strobe"); fail_count++; end

    wb_low_in_reset: assert property (@(posedge clk_i)
        rst_i |=> !wb_valid_i)
        else begin $error("wb_valid_o high during reset"); fail_count++; end

    no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_we_i |-> (wb_rd_i != 5'd0))
        else begin $error("wb_we_o high with wb_rd_o equal to x0"); fail_count++; end

    // Taken flag holds between records, so it may only move with a new one
    taken_with_wb: assert property (@(posedge clk_i) disable iff (rst_i)
        !$stable(branch_taken_i) |-> wb_valid_i)
        else begin $error("branch_taken_o changed without a writeback"); fail_count++; end

    x0_rs1_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        (inst_valid_i && inst_i[19:15] == 5'd0) |-> (rs1_data_i == 32'd0))
        else begin $error("x0 read nonzero on rs1"); fail_count++; end

    x0_rs2_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        (inst_valid_i && inst_i[24:20] == 5'd0) |-> (rs2_data_i == 32'd0))
        else begin $error("x0 read nonzero on rs2"); fail_count++; end

endmodule

bind rv_exec_top rv_exec_chk u_chk (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .wb_valid_i     (wb_valid_o),
    .wb_we_i        (wb_we_o),
    .wb_rd_i        (wb_rd_o),
    .branch_taken_i (branch_taken_o)
);

`default_nettype wire

// File: dv/rv_exec_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exec_tb;

    logic        clk_i;
    logic        rst_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic        wb_valid_o;
    logic        wb_we_o;
    logic        branch_taken_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic [31:0] next_pc_o;

    logic [31:0] lfsr = 32'd69933;
    logic [31:0] rf_model [32];   // Expected register contents
    int          tests = 0;
    int          failed_tests = 0;
    int          errors = 0;

    string      op_name [9] = '{"add", "sub", "sll", "slt", "xor", "srl", "sra", "or", "and"};
    logic [2:0] op_f3 [9]   = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic       op_alt [9]  = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    rv_exec_top DUT (.*);

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] i_inst(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("[FAIL] %s %s expected %h actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic issue(input string name, input logic [31:0] ins, input logic exp_we,
                         input logic [31:0] exp_data, input logic [31:0] exp_npc,
                         input logic exp_taken);
        int waited;
        int errors_before;
        errors_before = errors;
        inst_valid_i  = 1'b1;
        inst_i        = ins;
        @(negedge clk_i);
        inst_valid_i = 1'b0;
        inst_i       = '0;
        waited       = 0;
        while (!wb_valid_o && waited < 8) begin
            @(negedge clk_i);
            waited++;
        end
        if (!wb_valid_o) begin
            $display("Timeout waiting for the writeback of %s", name);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            if (waited != 0) begin
                $display("Writeback of %s arrived %0d cycles late", name, waited);
                errors++;
            end
            compare_field(name, "wb_we", {31'd0, exp_we}, {31'd0, wb_we_o});
            compare_field(name, "wb_rd", {27'd0, ins[11:7]}, {27'd0, wb_rd_o});
            compare_field(name, "next_pc", exp_npc, next_pc_o);
            compare_field(name, "branch_taken", {31'd0, exp_taken}, {31'd0, branch_taken_o});
            if (exp_we) begin
                compare_field(name, "wb_data", exp_data, wb_data_o);
                rf_model[ins[11:7]] = exp_data;
            end
            pc_i = pc_i + 32'd4;
            tests++;
            if (errors == errors_before) begin
                $display("[PASS] %s", name);
            end else begin
                failed_tests++;
                $display("%s finished with %0d errors", name, errors - errors_before);
            end
        end
    endtask

    task automatic alu_imm(input string name, input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] exp;
        exp = alu_ref(f3, f3 == 3'b101 && imm[10], rf_model[rs1], {{20{imm[11]}}, imm});
        issue(name, i_inst(imm, rs1, f3, rd, rv_pkg::OPCODE_OPIMM), rd != 5'd0, exp,
              pc_i + 32'd4, 1'b0);
    endtask

    // Full 32-bit value in 11 + 11 + 10 bit pieces
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        alu_imm("addi", 3'b000, rd, 5'd0, {v[31], v[31:21]});
        alu_imm("slli", 3'b001, rd, rd, 12'd11);
        alu_imm("ori", 3'b110, rd, rd, {1'b0, v[20:10]});
        alu_imm("slli", 3'b001, rd, rd, 12'd10);
        alu_imm("ori", 3'b110, rd, rd, {2'b00, v[9:0]});
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [12:0] off;
        logic [4:0]  rs2;
        logic        taken;
        clk_i        = 1'b0;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        for (int i = 0; i < 32; i++) begin
            rf_model[i] = '0;
        end
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        repeat (3) @(negedge clk_i);
        compare_field("reset", "wb_valid", 32'd0, {31'd0, wb_valid_o});
        compare_field("reset", "wb_we", 32'd0, {31'd0, wb_we_o});
        compare_field("reset", "branch_taken", 32'd0, {31'd0, branch_taken_o});
        compare_field("reset", "next_pc", 32'd0, next_pc_o);
        tests++;
        if (errors == 0) begin
            $display("[PASS] reset");
        end else begin
            failed_tests++;
            $display("reset finished with %0d errors", errors);
        end

        pc_i = 32'h0000_0100;
        for (int round = 0; round < 3; round++) begin
            take_bits(32, a);
            take_bits(32, b);
            load_reg(5'd1, a);
            load_reg(5'd2, b);
            for (int i = 0; i < 9; i++) begin
                issue(op_name[i], {1'b0, op_alt[i], 5'd0, 5'd2, 5'd1, op_f3[i], 5'd3,
                      rv_pkg::OPCODE_OP}, 1'b1,
                      alu_ref(op_f3[i], op_alt[i], rf_model[1], rf_model[2]),
                      pc_i + 32'd4, 1'b0);
                take_bits(12, r);
                if (op_f3[i] == 3'b001 || op_f3[i] == 3'b101) begin
                    r = {20'd0, 1'b0, op_alt[i], 5'd0, r[4:0]};
                end
                if (i != 1) begin
                    alu_imm({op_name[i], "i"}, op_f3[i], 5'd4, 5'd3, r[11:0]);   // Reads x3 at once
                end
            end
        end

        take_bits(12, r);
        for (int i = 0; i < 2; i++) begin
            off[11:0] = r[11:0] ^ {9'd0, i[0], 2'b00};   // Two neighbouring words
            rs2       = i[0] ? 5'd3 : 5'd2;
            issue("sw", {off[11:5], rs2, 5'd1, 3'b010, off[4:0], rv_pkg::OPCODE_STORE}, 1'b0,
                  32'd0, pc_i + 32'd4, 1'b0);
        end
        for (int i = 0; i < 2; i++) begin
            off[11:0] = r[11:0] ^ {9'd0, i[0], 2'b00};
            issue("lw", i_inst(off[11:0], 5'd1, 3'b010, 5'd5, rv_pkg::OPCODE_LOAD), 1'b1,
                  rf_model[i[0] ? 5'd3 : 5'd2], pc_i + 32'd4, 1'b0);
        end

        alu_imm("addi", 3'b000, 5'd7, 5'd1, 12'd1);   // x7 differs from x1
        for (int k = 0; k < 8; k++) begin
            off   = k[2] ? 13'h1FE0 : 13'd20;
            rs2   = k[1] ? 5'd7 : 5'd1;
            taken = (rf_model[1] == rf_model[rs2]) ^ k[0];
            issue(k[0] ? "bne" : "beq", {off[12], off[10:5], rs2, 5'd1, 2'b00, k[0], off[4:1],
                  off[11], rv_pkg::OPCODE_BRANCH}, 1'b0, 32'd0,
                  taken ? pc_i + {{19{off[12]}}, off} : pc_i + 32'd4, taken);
        end

        issue("jal", {1'b0, 10'd512, 1'b0, 8'd0, 5'd8, rv_pkg::OPCODE_JAL}, 1'b1,
              pc_i + 32'd4, pc_i + 32'd1024, 1'b0);
        issue("jal x0", {1'b1, 10'd0, 1'b1, 8'hFF, 5'd0, rv_pkg::OPCODE_JAL}, 1'b0,
              32'd0, pc_i - 32'd2048, 1'b0);
        take_bits(12, r);
        r[0] = ~rf_model[1][0];   // Odd sum so bit 0 gets cleared
        issue("jalr", i_inst(r[11:0], 5'd1, 3'b000, 5'd9, rv_pkg::OPCODE_JALR), 1'b1,
              pc_i + 32'd4, (rf_model[1] + {{20{r[11]}}, r[11:0]}) & ~32'd1, 1'b0);
        issue("jalr x0", i_inst(12'd3, 5'd2, 3'b000, 5'd0, rv_pkg::OPCODE_JALR), 1'b0,
              32'd0, (rf_model[2] + 32'd3) & ~32'd1, 1'b0);
        alu_imm("addi from x0", 3'b000, 5'd10, 5'd0, 12'd5);

        take_bits(25, r);
        issue("unknown opcode", {r[24:0], 7'b0001011}, 1'b0, 32'd0, pc_i + 32'd4, 1'b0);

        repeat (2) @(negedge clk_i);
        $display("Tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 tests, failed_tests, errors, DUT.u_chk.fail_count);
        if (errors == 0 && DUT.u_chk.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/rv_pkg.sv
design/decode_if.sv
design/decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/rv_exec_top.sv
dv/rv_exec_chk.sv
dv/rv_exec_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f compile.f --top-module rv_exec_tb -o rv_exec_sim

./obj_dir/rv_exec_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
